// File: src/opfetch_pkg.sv
/*
 * Operand fetch package
 * Opcode encodings, the instruction word with its decode views, register
 * numbering and the request and response records of the register-file port
 */
package opfetch_pkg;

	// ====================
	// Opcodes and instruction word
	// ====================

	typedef enum logic [6:0] {
		R2   = 7'h02,
		BSET = 7'h0E,
		STO  = 7'h13,
		STOX = 7'h1B,
		JMP  = 7'h20,
		JEQ  = 7'h26,
		JNE  = 7'h27,
		BEQZ = 7'h30,
		RTS  = 7'h32,
		MTLK = 7'h4C
	} opcode_e;

	// Register index, values 48 and up have no storage behind them
	typedef logic [5:0] reg_idx_t;

	typedef struct packed {
		logic [24:0] rsvd;
		opcode_e     opcode;
	} ir_any_t;

	// Three-register form, Rc sits right above the two spare bits
	typedef struct packed {
		logic [10:0] rsvd;
		reg_idx_t    ra;
		reg_idx_t    rc;
		logic [1:0]  spare;
		opcode_e     opcode;
	} ir_r3_t;

	// Stores carry a five-bit source register
	typedef struct packed {
		logic [10:0] rsvd;
		reg_idx_t    ra;
		logic        rsvd_rs;
		logic [4:0]  rs;
		logic [1:0]  spare;
		opcode_e     opcode;
	} ir_st_t;

	// Conditional and plain jumps compare against Rc
	typedef struct packed {
		logic [10:0] rsvd;
		reg_idx_t    ra;
		reg_idx_t    rc;
		logic [1:0]  spare;
		opcode_e     opcode;
	} ir_jxx_t;

	typedef union packed {
		ir_any_t any;
		ir_r3_t  r3;
		ir_st_t  st;
		ir_jxx_t jxx;
	} instruction_t;

	// ====================
	// Register numbering
	// ====================

	localparam reg_idx_t SP_REG      = 6'd31;
	localparam reg_idx_t LK1_REG     = 6'd41;
	localparam reg_idx_t LK2_REG     = 6'd42;
	localparam reg_idx_t SP_ALT_BASE = 6'd44;
	localparam int       NUM_REGS    = 48;

	// Fields that point past the implemented range fold back onto 16..31
	function automatic reg_idx_t fold_idx(reg_idx_t idx);
		if (idx >= NUM_REGS)
			return {1'b0, idx[4:0]};
		return idx;
	endfunction

	// The stack pointer is banked, selector values 1 to 4 pick 44 to 47
	function automatic reg_idx_t sp_subst(reg_idx_t idx, logic [2:0] sp_sel);
		if (idx == SP_REG && sp_sel >= 3'd1 && sp_sel <= 3'd4)
			return SP_ALT_BASE + reg_idx_t'(sp_sel) - 6'd1;
		return idx;
	endfunction

	// ====================
	// Register-file port records
	// ====================

	typedef struct packed {
		logic        valid;
		logic        write;
		reg_idx_t    index;
		logic [63:0] wdata;
	} rf_req_t;

	typedef struct packed {
		logic        valid;
		logic [63:0] rdata;
	} rf_rsp_t;

	typedef struct packed {
		reg_idx_t    rc_idx;
		reg_idx_t    ra_idx;
		logic [63:0] rc_val;
		logic [63:0] ra_val;
	} operand_t;

endpackage

// File: src/decode_rc.sv
/*
 * Rc index decoder
 * Picks the store-data or comparand register out of the instruction word,
 * maps the link aliases and applies the banked stack pointer
 */
`timescale 1ns/1ps

module decode_rc import opfetch_pkg::*; (
	input  instruction_t ir,
	input  logic [2:0]   sp_sel,
	output reg_idx_t     rc
);

	reg_idx_t rc_raw;
	// Set when the opcode names its register exactly and banking must not apply
	logic forced;

	always_comb
	begin
		forced = 1'b0;
		rc_raw = fold_idx(ir.r3.rc);
		case (ir.any.opcode)
			R2:
				rc_raw = fold_idx(ir.r3.rc);
			STO, STOX:
				rc_raw = {1'b0, ir.st.rs};
			BSET:
				rc_raw = LK2_REG;
			JEQ, JNE, JMP:
			begin
				forced = 1'b1;
				// Jumps name the link registers through the aliases 29 and 30
				case (ir.jxx.rc)
					6'd29:   rc_raw = LK1_REG;
					6'd30:   rc_raw = LK2_REG;
					default: rc_raw = fold_idx(ir.jxx.rc);
				endcase
			end
			BEQZ:
			begin
				forced = 1'b1;
				rc_raw = SP_REG;
			end
			RTS:
				// Zero means no link register, otherwise one of 41 to 43
				rc_raw = (ir[10:9] == 2'd0) ? 6'd0 : {4'b1010, ir[10:9]};
			MTLK:
				rc_raw = {1'b0, ir[13:9]};
			default:
				rc_raw = fold_idx(ir.r3.rc);
		endcase
		rc = forced ? rc_raw : sp_subst(rc_raw, sp_sel);
	end

	// Every opcode path has to land on an implemented register
	always_comb
	begin
		assert (rc < NUM_REGS)
			else $error("decode_rc produced index %0d", rc);
	end

endmodule

// File: src/regfile.sv
/*
 * Register file
 * 48 words behind one request port, reads answer on the next cycle
 */
`timescale 1ns/1ps

module regfile import opfetch_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic    clk,
	input  logic    rst_n,
	input  rf_req_t req,
	output rf_rsp_t rsp
);

	logic [DATA_W-1:0] mem [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				mem[i] <= '0;
			rsp <= '0;
		end
		else
		begin
			rsp.valid <= req.valid;
			// Writes and unimplemented indices answer with zero
			rsp.rdata <= '0;
			if (req.valid && req.index < NUM_REGS)
			begin
				if (req.write)
					mem[req.index] <= req.wdata[DATA_W-1:0];
				else
					rsp.rdata <= 64'(mem[req.index]);
			end
		end
	end

	// Both requesters filter their indices upstream
	assert property (@(posedge clk) disable iff (!rst_n)
		req.valid |-> req.index < NUM_REGS)
		else $error("register index %0d out of range", req.index);

endmodule

// File: src/reg_arbiter.sv
/*
 * Register-file arbiter
 * Round-robin between the operand fetcher and the APB host port,
 * the response is steered back to whoever won the cycle before
 */
`timescale 1ns/1ps

module reg_arbiter import opfetch_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  rf_req_t fetch_req,
	output logic    fetch_gnt,
	output rf_rsp_t fetch_rsp,
	input  rf_req_t host_req,
	output logic    host_gnt,
	output rf_rsp_t host_rsp,
	output rf_req_t rf_req,
	input  rf_rsp_t rf_rsp
);

	// High when the host wins a tie
	logic host_prio;
	// Which side the response in flight belongs to
	logic owner_host;

	// ====================
	// Grant and forward
	// ====================

	assign fetch_gnt = fetch_req.valid && (!host_req.valid || !host_prio);
	assign host_gnt  = host_req.valid && (!fetch_req.valid || host_prio);

	always_comb
	begin
		rf_req       = host_gnt ? host_req : fetch_req;
		rf_req.valid = fetch_gnt || host_gnt;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			host_prio  <= 1'b0;
			owner_host <= 1'b0;
		end
		else
		begin
			// The side that just won drops to the back
			if (fetch_gnt || host_gnt)
				host_prio <= fetch_gnt;
			owner_host <= host_gnt;
		end
	end

	// ====================
	// Response routing
	// ====================

	always_comb
	begin
		fetch_rsp       = rf_rsp;
		host_rsp        = rf_rsp;
		fetch_rsp.valid = rf_rsp.valid && !owner_host;
		host_rsp.valid  = rf_rsp.valid && owner_host;
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(fetch_gnt && host_gnt))
		else $error("both requesters granted");

endmodule

// File: src/apb_reg_port.sv
/*
 * APB register port
 * Lets a debug host read and write the register file, one word per
 * transfer at paddr[7:2], out-of-range words end in a slave error
 */
`timescale 1ns/1ps

module apb_reg_port import opfetch_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [7:0]        paddr,
	input  logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0] prdata,
	output logic              pready,
	output logic              pslverr,
	output rf_req_t           req,
	input  logic              gnt,
	input  rf_rsp_t           rsp
);

	typedef enum logic [1:0] {A_IDLE, A_REQ, A_WAIT} state_e;

	state_e   state;
	reg_idx_t index;
	logic     bad_index;

	assign index     = paddr[7:2];
	assign bad_index = index >= NUM_REGS;

	// Address and data are held by the master for the whole transfer
	assign req = '{valid: state == A_REQ, write: pwrite, index: index, wdata: 64'(pwdata)};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= A_IDLE;
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end
		else
		begin
			// Completion flags are single-cycle pulses
			pready  <= 1'b0;
			pslverr <= 1'b0;
			case (state)
				A_IDLE:
					// Start on the setup phase so a bad word ends in the first access cycle
					if (psel && !penable)
					begin
						if (bad_index)
						begin
							pready  <= 1'b1;
							pslverr <= 1'b1;
						end
						else
							state <= A_REQ;
					end
				A_REQ:
					if (gnt)
						state <= A_WAIT;
				A_WAIT:
					if (rsp.valid)
					begin
						pready <= 1'b1;
						state  <= A_IDLE;
					end
				default:
					state <= A_IDLE;
			endcase
		end
	end

	// Read data lines up with pready, writes return zero
	always_ff @(posedge clk)
	begin
		if (state == A_WAIT && rsp.valid)
			prdata <= rsp.rdata[DATA_W-1:0];
	end

endmodule

// File: src/operand_fetch.sv
/*
 * Operand fetch
 * Takes one instruction, reads Ra then Rc through the shared register
 * port and presents both indices and values as one bundle
 */
`timescale 1ns/1ps

module operand_fetch import opfetch_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,
	output logic         in_ready,
	input  instruction_t ir,
	input  logic [2:0]   sp_sel,
	output logic         out_valid,
	input  logic         out_ready,
	output operand_t     operand,
	output rf_req_t      req,
	input  logic         gnt,
	input  rf_rsp_t      rsp
);

	// Keeps the unused top of the 64-bit data path at zero
	localparam logic [63:0] DATA_MASK = {64{1'b1}} >> (64 - DATA_W);

	// S_INIT holds off intake for one cycle after reset
	typedef enum logic [2:0] {S_INIT, S_IDLE, S_RA, S_RC, S_WAIT, S_OUT} state_e;

	state_e       state;
	instruction_t ir_q;
	logic [2:0]   sp_sel_q;
	reg_idx_t     rc_idx;
	reg_idx_t     ra_idx;
	logic [63:0]  ra_val;
	logic [63:0]  rc_val;

	// ====================
	// Index decode
	// ====================

	decode_rc u_decode_rc (
		.ir     (ir_q),
		.sp_sel (sp_sel_q),
		.rc     (rc_idx)
	);

	// Ra has no fixed registers so banking always applies
	assign ra_idx = sp_subst(fold_idx(ir_q.r3.ra), sp_sel_q);

	// ====================
	// Read sequence
	// ====================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= S_INIT;
		else
		begin
			case (state)
				S_INIT: state <= S_IDLE;
				S_IDLE: if (in_valid) state <= S_RA;
				S_RA:   if (gnt) state <= S_RC;
				S_RC:   if (gnt) state <= S_WAIT;
				S_WAIT: if (rsp.valid) state <= S_OUT;
				S_OUT:  if (out_ready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
		begin
			ir_q     <= ir;
			sp_sel_q <= sp_sel;
		end
		// The Ra answer always lands while the Rc read is still pending
		if (state == S_RC && rsp.valid)
			ra_val <= rsp.rdata & DATA_MASK;
		if (state == S_WAIT && rsp.valid)
			rc_val <= rsp.rdata & DATA_MASK;
	end

	assign in_ready  = state == S_IDLE;
	assign out_valid = state == S_OUT;

	always_comb
	begin
		req       = '0;
		req.valid = state == S_RA || state == S_RC;
		req.index = (state == S_RC) ? rc_idx : ra_idx;
	end

	// Everything here is registered so the bundle holds under back-pressure
	assign operand = '{rc_idx: rc_idx, ra_idx: ra_idx, rc_val: rc_val, ra_val: ra_val};

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(operand))
		else $error("operand bundle changed while stalled");

endmodule

// File: src/opfetch_top.sv
/*
 * Operand fetch top level
 * Fetcher and APB host port share the register file through the arbiter
 */
`timescale 1ns/1ps

module opfetch_top import opfetch_pkg::*; #(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  instruction_t      ir,
	input  logic [2:0]        sp_sel,
	output logic              out_valid,
	input  logic              out_ready,
	output operand_t          operand,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [7:0]        paddr,
	input  logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0] prdata,
	output logic              pready,
	output logic              pslverr
);

	rf_req_t fetch_req;
	rf_req_t host_req;
	rf_req_t rf_req;
	rf_rsp_t fetch_rsp;
	rf_rsp_t host_rsp;
	rf_rsp_t rf_rsp;
	logic    fetch_gnt;
	logic    host_gnt;

	operand_fetch #(.DATA_W(DATA_W)) u_operand_fetch (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.ir        (ir),
		.sp_sel    (sp_sel),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.operand   (operand),
		.req       (fetch_req),
		.gnt       (fetch_gnt),
		.rsp       (fetch_rsp)
	);

	apb_reg_port #(.DATA_W(DATA_W)) u_apb_reg_port (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.req     (host_req),
		.gnt     (host_gnt),
		.rsp     (host_rsp)
	);

	reg_arbiter u_reg_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.fetch_req (fetch_req),
		.fetch_gnt (fetch_gnt),
		.fetch_rsp (fetch_rsp),
		.host_req  (host_req),
		.host_gnt  (host_gnt),
		.host_rsp  (host_rsp),
		.rf_req    (rf_req),
		.rf_rsp    (rf_rsp)
	);

	regfile #(.DATA_W(DATA_W)) u_regfile (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (rf_req),
		.rsp   (rf_rsp)
	);

endmodule

// File: testbench/tb_opfetch.sv
/*
 * Operand fetch testbench
 * Loads the register file over APB, then runs random instructions against
 * a reference model of the Rc and Ra index rules while the host keeps
 * reading and writing through the shared register port
 */
`timescale 1ns/1ps

module tb_opfetch import opfetch_pkg::*; ();

	localparam int DATA_W        = 32;
	localparam int CLK_PERIOD    = 4;
	localparam int NUM_INSTR     = 300;
	localparam int NUM_MIXED_APB = 300;
	// Load, out-of-range write and read probes, readback, then the mixed phase
	localparam int TOTAL_TXN      = NUM_REGS + 32 + NUM_REGS + NUM_INSTR + NUM_MIXED_APB;
	localparam int TIMEOUT_CYCLES = 20 * TOTAL_TXN * 10;

	localparam opcode_e OP_LIST [10] = '{R2, STO, STOX, BSET, JEQ, JNE, JMP, BEQZ, RTS, MTLK};

	// What the model expects from one instruction, with register values at intake
	typedef struct packed {
		reg_idx_t          rc_idx;
		reg_idx_t          ra_idx;
		logic [DATA_W-1:0] rc_old;
		logic [DATA_W-1:0] ra_old;
	} expect_t;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic              in_ready;
	instruction_t      ir;
	logic [2:0]        sp_sel;
	logic              out_valid;
	logic              out_ready;
	operand_t          operand;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [7:0]        paddr;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;
	logic              pready;
	logic              pslverr;

	integer            seed;
	integer            host_seed;
	integer            ready_seed;
	int                value_errors = 0;
	int                other_errors = 0;
	int                checks = 0;
	int                cycles = 0;
	int                out_count = 0;
	logic [DATA_W-1:0] model_regs [NUM_REGS];
	expect_t           pending [$];
	operand_t          held;
	logic              holding;

	opfetch_top #(.DATA_W(DATA_W)) u_opfetch_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.ir        (ir),
		.sp_sel    (sp_sel),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.operand   (operand),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	// Ends a run where either side has stopped completing
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, %0d of %0d operand bundles delivered",
				cycles, out_count, NUM_INSTR);
			$display("Checks: %0d, value errors: %0d, other errors: %0d",
				checks, value_errors, other_errors);
			$display("Something failed");
			$finish;
		end
	end

	// ====================
	// Reference model
	// ====================

	// Fields past the last register land on 16 to 31
	function automatic reg_idx_t fold_model(reg_idx_t field);
		if (field >= NUM_REGS)
			return field - 6'd32;
		return field;
	endfunction

	// Register 31 is banked onto 44 to 47 when the selector is 1 to 4
	function automatic reg_idx_t bank_model(reg_idx_t idx, logic [2:0] sel);
		if (idx == 6'd31 && sel >= 3'd1 && sel <= 3'd4)
			return 6'd43 + 6'(sel);
		return idx;
	endfunction

	function automatic reg_idx_t expect_rc(logic [31:0] word, logic [2:0] sel);
		reg_idx_t idx;
		case (word[6:0])
			STO, STOX:
				idx = {1'b0, word[13:9]};
			BSET:
				idx = 6'd42;
			JEQ, JNE, JMP:
				// Jumps are never banked, 29 and 30 stand for the link registers
				case (word[14:9])
					6'd29:   return 6'd41;
					6'd30:   return 6'd42;
					default: return fold_model(word[14:9]);
				endcase
			BEQZ:
				return 6'd31;
			RTS:
				idx = (word[10:9] == 2'd0) ? 6'd0 : 6'd40 + 6'(word[10:9]);
			MTLK:
				idx = {1'b0, word[13:9]};
			default:
				idx = fold_model(word[14:9]);
		endcase
		return bank_model(idx, sel);
	endfunction

	function automatic reg_idx_t expect_ra(logic [31:0] word, logic [2:0] sel);
		return bank_model(fold_model(word[20:15]), sel);
	endfunction

	// A host write may land on either side of a fetch read
	function automatic logic value_ok(logic [63:0] got, logic [DATA_W-1:0] old, reg_idx_t idx);
		return got === 64'(old) || got === 64'(model_regs[idx]);
	endfunction

	task automatic report_value(input string msg);
		value_errors++;
		$display("FAILED at %0t: %s", $time, msg);
	endtask

	// ====================
	// APB host
	// ====================

	// Starts on a falling edge and returns on the falling edge where pready is seen
	task automatic apb_access(input logic write, input logic [7:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		while (!pready)
			@(negedge clk);
		rdata   = prdata;
		err     = pslverr;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic host_access(input logic write, input int idx, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] rdata;
		logic              err;
		apb_access(write, 8'(idx << 2), data, rdata, err);
		checks++;
		if (err !== (idx >= NUM_REGS))
			report_value($sformatf("pslverr %b for register %0d", err, idx));
		else if (idx < NUM_REGS && write)
			model_regs[idx] = data;
		else if (idx < NUM_REGS && rdata !== model_regs[idx])
			report_value($sformatf("register %0d read 0x%0h, expected 0x%0h",
				idx, rdata, model_regs[idx]));
	endtask

	task automatic mixed_host_traffic();
		int wr_idx;
		wr_idx = 0;
		for (int n = 0; n < NUM_MIXED_APB; n++)
		begin
			if ({$random(host_seed)} % 2 == 0)
			begin
				// Stepping by 5 revisits a register only every 48 writes
				host_access(1'b1, wr_idx, $random(host_seed));
				wr_idx = (wr_idx + 5) % NUM_REGS;
			end
			else
				host_access(1'b0, {$random(host_seed)} % NUM_REGS, '0);
			repeat ({$random(host_seed)} % 3)
				@(negedge clk);
		end
	endtask

	// ====================
	// Instruction side
	// ====================

	task automatic send_instr();
		logic [31:0] word;
		logic [2:0]  sel;
		int          k;
		expect_t     want;
		word = $random(seed);
		sel  = 3'($random(seed));
		k    = {$random(seed)} % 11;
		// Slot 10 gives an arbitrary opcode for the default decode
		word[6:0] = (k == 10) ? 7'($random(seed)) : OP_LIST[k];
		if ({$random(seed)} % 4 == 0)
			word[14:9] = 6'd29 + 6'({$random(seed)} % 3);
		in_valid = 1'b1;
		ir       = word;
		sp_sel   = sel;
		while (!in_ready)
			@(negedge clk);
		// Accepted on the coming rising edge
		want.rc_idx = expect_rc(word, sel);
		want.ra_idx = expect_ra(word, sel);
		want.rc_old = model_regs[want.rc_idx];
		want.ra_old = model_regs[want.ra_idx];
		pending.push_back(want);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic check_bundle();
		expect_t want;
		if (pending.size() == 0)
		begin
			other_errors++;
			$display("Operand bundle delivered at %0t with no instruction outstanding", $time);
			return;
		end
		want    = pending.pop_front();
		held    = operand;
		holding = 1'b1;
		checks++;
		if (operand.rc_idx !== want.rc_idx)
			report_value($sformatf("rc index %0d, expected %0d", operand.rc_idx, want.rc_idx));
		if (operand.ra_idx !== want.ra_idx)
			report_value($sformatf("ra index %0d, expected %0d", operand.ra_idx, want.ra_idx));
		if (!value_ok(operand.rc_val, want.rc_old, want.rc_idx))
			report_value($sformatf("rc value 0x%0h for register %0d", operand.rc_val, want.rc_idx));
		if (!value_ok(operand.ra_val, want.ra_old, want.ra_idx))
			report_value($sformatf("ra value 0x%0h for register %0d", operand.ra_val, want.ra_idx));
	endtask

	// Output side with random back-pressure
	initial
	begin
		out_ready = 1'b0;
		holding   = 1'b0;
		forever
		begin
			@(negedge clk);
			if (out_valid && !holding)
				check_bundle();
			else if (out_valid && operand !== held)
				report_value("operand bundle changed while out_ready was low");
			out_ready = ({$random(ready_seed)} % 3) != 0;
			if (out_valid && out_ready)
			begin
				holding = 1'b0;
				out_count++;
			end
		end
	end

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		seed       = 54;
		ready_seed = $random(seed);
		host_seed  = $random(seed);
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		ir         = '0;
		sp_sel     = 3'd0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = 8'd0;
		pwdata     = '0;
		repeat (2)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		checks++;
		if (out_valid !== 1'b0 || pready !== 1'b0 || pslverr !== 1'b0 || in_ready !== 1'b1)
			report_value($sformatf("after reset out_valid=%b pready=%b pslverr=%b in_ready=%b",
				out_valid, pready, pslverr, in_ready));

		// Load every register, probe the missing words, then read all back
		for (int i = 0; i < NUM_REGS; i++)
			host_access(1'b1, i, $random(host_seed));
		for (int i = NUM_REGS; i < 64; i++)
		begin
			host_access(1'b1, i, $random(host_seed));
			host_access(1'b0, i, '0);
		end
		for (int i = 0; i < NUM_REGS; i++)
			host_access(1'b0, i, '0);

		// Instruction traffic and host traffic compete for the register port
		fork
			begin
				for (int n = 0; n < NUM_INSTR; n++)
				begin
					send_instr();
					repeat ({$random(seed)} % 3)
						@(negedge clk);
				end
			end
			mixed_host_traffic();
		join
		while (out_count < NUM_INSTR)
			@(negedge clk);
		// An extra bundle would surface within a few cycles of the last one
		repeat (8)
			@(negedge clk);
		if (out_count != NUM_INSTR || out_valid)
		begin
			other_errors++;
			$display("Fetcher did not settle, %0d bundles delivered for %0d instructions",
				out_count, NUM_INSTR);
		end

		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: vlog.f
src/opfetch_pkg.sv
src/decode_rc.sv
src/regfile.sv
src/reg_arbiter.sv
src/apb_reg_port.sv
src/operand_fetch.sv
src/opfetch_top.sv
testbench/tb_opfetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the operand fetch testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_opfetch -o tb_opfetch

# The run passes only if the pass line shows up in the output
./obj_dir/tb_opfetch | tee /dev/stderr | grep -qx "Everything OK"
echo "Simulation passed"
